/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tbFastCycle
FILELIST = tb.f
OBJDIR = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Output is shown, then searched for the pass message
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* logic/cpuPort.sv */
`default_nettype none

// Host access to the fast VRAM through the CPU slot
module cpuPort import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic TEST,
	input wire slot_t slot,
	input wire logic [ADDR_W-1:0] cpuAddr,
	input wire logic reload,
	input wire logic [10:0] vramMod,
	input wire logic cpuWrite,
	input wire logic [DATA_W-1:0] cpuWrData,
	input wire logic [DATA_W-1:0] rdData,
	output vramReq_t cpuReq,
	output logic [DATA_W-1:0] cpuRdData,
	output logic writeAck
);

	logic [ADDR_W-1:0] addrReg;	// Current host address
	logic [DATA_W-1:0] wrDataReg;	// Held write word
	logic pending;	// Write waiting for slot 0

	// Access goes out in slot 0 only
	always_comb
	begin
		cpuReq.addr = addrReg;
		cpuReq.wrData = wrDataReg;
		cpuReq.write = pending && (slot == 5'd0);
	end

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			addrReg <= '0;
			pending <= 1'b0;
			writeAck <= 1'b0;
		end
		else
		begin
			writeAck <= cpuReq.write;	// High during slot 1 after a write
			if (reload)
				addrReg <= cpuAddr;	// Reload beats the increment
			else if (cpuReq.write)
				addrReg <= addrReg + vramMod;	// Wraps at 2048
			if (cpuReq.write)
				pending <= 1'b0;
			else if (cpuWrite)
				pending <= 1'b1;	// A second strobe while pending is dropped
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (cpuWrite && !pending)
			wrDataReg <= cpuWrData;
		if ((slot == 5'd1) && !writeAck)
			cpuRdData <= rdData;	// Slot 0 was a read
	end

endmodule

`default_nettype wire

/* logic/fastCycleTop.sv */
`default_nettype none

// Fast VRAM with its three clients
module fastCycleTop import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic TEST,
	input wire logic lineBlank,
	input wire logic [8:0] vCount,
	input wire logic bankFlip,
	input wire logic [ADDR_W-1:0] cpuAddr,
	input wire logic reload,
	input wire logic [10:0] vramMod,
	input wire logic cpuWrite,
	input wire logic [DATA_W-1:0] cpuWrData,
	output logic [DATA_W-1:0] cpuRdData,
	output logic writeAck,
	output sprAttr_t sprAttr,
	output logic sprValid
);

	slot_t slot;
	vramReq_t cpuReq;
	vramReq_t parseReq;
	logic [ADDR_W-1:0] renderAddr;
	logic [ADDR_W-1:0] ramAddr;
	logic [DATA_W-1:0] ramWrData;
	logic ramWrite;
	logic [DATA_W-1:0] rdData;	// Shared by all clients

	fastVram vram (.CLK_24M, .addr(ramAddr), .wrData(ramWrData), .write(ramWrite), .rdData);

	slotSequencer sequencer (.CLK_24M, .TEST, .lineBlank, .cpuReq, .parseReq, .renderAddr,
		.slot, .ramAddr, .ramWrData, .ramWrite);

	cpuPort cpu (.CLK_24M, .TEST, .slot, .cpuAddr, .reload, .vramMod, .cpuWrite, .cpuWrData,
		.rdData, .cpuReq, .cpuRdData, .writeAck);

	// Builds the list for bank bankFlip
	spriteParser parser (.CLK_24M, .TEST, .lineBlank, .slot, .vCount, .bankFlip, .rdData,
		.parseReq);

	// Reads the other bank
	renderFetch render (.CLK_24M, .TEST, .lineBlank, .slot, .vCount, .bankFlip, .rdData,
		.renderAddr, .sprAttr, .sprValid);

endmodule

`default_nettype wire

/* logic/fastVram.sv */
`default_nettype none

// 2K x 16 fast VRAM, single port
module fastVram import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic [ADDR_W-1:0] addr,
	input wire logic [DATA_W-1:0] wrData,
	input wire logic write,
	output logic [DATA_W-1:0] rdData
);

	logic [DATA_W-1:0] mem [1 << ADDR_W];	// Contents survive TEST

	// Write and registered read on the same edge
	// Same-address access returns the old word
	always_ff @(posedge CLK_24M)
	begin
		if (write)
			mem[addr] <= wrData;
		rdData <= mem[addr];	// Valid in the slot after the address
	end

endmodule

`default_nettype wire

/* logic/renderFetch.sv */
`default_nettype none

// Reads back the previous line's list and gathers attributes
module renderFetch import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic TEST,
	input wire logic lineBlank,
	input wire slot_t slot,
	input wire logic [8:0] vCount,
	input wire logic bankFlip,
	input wire logic [DATA_W-1:0] rdData,
	output logic [ADDR_W-1:0] renderAddr,
	output sprAttr_t sprAttr,
	output logic sprValid
);

	logic [6:0] readCount;	// Active list read position
	logic busy;	// Until END_MARK is seen
	logic primed;	// A list has been built at least once
	logic haveEntry;	// Current group carries a sprite
	logic [8:0] renderLine;

	assign renderLine = rdData[15:7] + vCount;	// yPos + vCount, mod 512

	// Address follows the slot, opposite bank for the list
	always_comb
	begin
		if (slot >= SLOT_SCB4)
			renderAddr = SCB4_BASE | ADDR_W'(sprAttr.index);
		else if (slot >= SLOT_SCB3)
			renderAddr = SCB3_BASE | ADDR_W'(sprAttr.index);
		else if (slot >= SLOT_SCB2)
			renderAddr = SCB2_BASE | ADDR_W'(sprAttr.index);
		else
			renderAddr = AL_BASE | ADDR_W'({~bankFlip, readCount});
	end

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			busy <= 1'b0;
			primed <= 1'b0;
			haveEntry <= 1'b0;
			sprValid <= 1'b0;
			readCount <= '0;
		end
		else if (lineBlank)
		begin
			busy <= primed;	// No list behind the first line
			primed <= 1'b1;
			haveEntry <= 1'b0;
			sprValid <= 1'b0;
			readCount <= '0;
		end
		else
		begin
			sprValid <= 1'b0;
			if (busy && (slot == SLOT_AL_READ + 5'd1))
			begin
				if (|(rdData & END_MARK))
					busy <= 1'b0;	// Rest of line is empty
				else
					haveEntry <= 1'b1;
			end
			if (haveEntry && (slot == SLOT_SCB4 + 5'd1))
				sprValid <= 1'b1;	// High during slot 31
			if (sprValid)
			begin
				haveEntry <= 1'b0;
				readCount <= readCount + 7'd1;
			end
		end
	end

	// Each word sampled in the slot after its read
	always_ff @(posedge CLK_24M)
	begin
		case (slot)
			SLOT_AL_READ + 5'd1: sprAttr.index <= rdData[8:0];
			SLOT_SCB2 + 5'd1: sprAttr.shrink <= rdData[11:0];
			SLOT_SCB3 + 5'd1:
			begin
				sprAttr.sticky <= rdData[6];
				sprAttr.size <= rdData[5:0];
				sprAttr.tileIdx <= renderLine[8:4];	// Tile row
				sprAttr.tileLine <= renderLine[3:0];	// Line in tile
			end
			SLOT_SCB4 + 5'd1: sprAttr.xPos <= rdData[15:7];
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/slotSequencer.sv */
`default_nettype none

// Group slot counter and fast RAM access mux
module slotSequencer import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic TEST,
	input wire logic lineBlank,
	input wire vramReq_t cpuReq,
	input wire vramReq_t parseReq,
	input wire logic [ADDR_W-1:0] renderAddr,
	output slot_t slot,
	output logic [ADDR_W-1:0] ramAddr,
	output logic [DATA_W-1:0] ramWrData,
	output logic ramWrite
);

	logic cpuOwns;	// Slots 0..2
	logic parseOwns;	// Slots 3..18

	// Free-running, restarted by lineBlank each line
	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
			slot <= '0;
		else if (lineBlank)
			slot <= '0;	// Held at 0 while lineBlank is high
		else
			slot <= slot + 5'd1;	// Wraps 31 -> 0
	end

	assign cpuOwns = (slot <= SLOT_CPU_LAST);
	assign parseOwns = (slot >= SLOT_PARSE_FIRST) && (slot < SLOT_AL_READ);

	// Owner of the slot drives the RAM
	always_comb
	begin
		if (cpuOwns)
		begin
			ramAddr = cpuReq.addr;
			ramWrData = cpuReq.wrData;
			ramWrite = cpuReq.write;
		end
		else if (parseOwns)
		begin
			ramAddr = parseReq.addr;
			ramWrData = parseReq.wrData;
			ramWrite = parseReq.write;
		end
		else
		begin
			// Render slots, reads only
			ramAddr = renderAddr;
			ramWrData = '0;
			ramWrite = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/spriteParser.sv */
`default_nettype none

// Vertical scan of SCB3, builds the next line's active list
module spriteParser import spritePkg::*;
(
	input wire logic CLK_24M,
	input wire logic TEST,
	input wire logic lineBlank,
	input wire slot_t slot,
	input wire logic [8:0] vCount,
	input wire logic bankFlip,
	input wire logic [DATA_W-1:0] rdData,
	output vramReq_t parseReq
);

	logic [8:0] parseIdx;	// Next sprite to read
	logic [6:0] fillCount;	// Next active list entry
	logic [8:0] matchIdx;	// Last read sprite
	logic matched;	// matchIdx waits for its write
	logic sample;	// SCB3 word arrives this slot
	logic busy;	// Cleared once END_MARK is out
	slot_t rel;
	logic inParse;
	logic windowStart;
	logic scanDone;
	logic [8:0] offset;
	logic hit;

	// Window position inside the parse slots
	assign rel = slot - SLOT_PARSE_FIRST;
	assign inParse = (slot >= SLOT_PARSE_FIRST) && (rel < PARSE_WIN * PARSE_COUNT);
	assign windowStart = inParse && ((rel % PARSE_WIN) == 0);	// 3, 6, 9, 12, 15

	assign scanDone = (parseIdx == 9'(SPRITE_COUNT)) || (fillCount == 7'(ACTIVE_MAX));

	// Match against the next line
	assign offset = rdData[15:7] + vCount + 9'd1;	// yPos + vCount + 1, mod 512
	assign hit = (rdData[5:0] != 6'd0) && ({1'b0, offset[8:4]} < rdData[5:0]);

	always_comb
	begin
		// Write a pending match or the end marker, else read SCB3
		parseReq.write = windowStart && busy && (matched || scanDone);
		if (matched || scanDone)
			parseReq.addr = AL_BASE | ADDR_W'({bankFlip, fillCount});
		else
			parseReq.addr = SCB3_BASE | ADDR_W'(parseIdx);
		parseReq.wrData = matched ? DATA_W'(matchIdx) : END_MARK;
	end

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			busy <= 1'b0;	// Idle until first lineBlank
			matched <= 1'b0;
			sample <= 1'b0;
			parseIdx <= '0;
			fillCount <= '0;
		end
		else if (lineBlank)
		begin
			busy <= 1'b1;	// New scan for this line
			matched <= 1'b0;
			sample <= 1'b0;
			parseIdx <= '0;
			fillCount <= '0;
		end
		else
		begin
			sample <= 1'b0;
			if (sample)
			begin
				matched <= hit;
				parseIdx <= parseIdx + 9'd1;
			end
			if (windowStart && busy)
			begin
				if (matched)
				begin
					matched <= 1'b0;	// Entry written
					fillCount <= fillCount + 7'd1;
				end
				else if (scanDone)
					busy <= 1'b0;	// END_MARK written, idle till next line
				else
					sample <= 1'b1;	// Read issued
			end
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (sample)
			matchIdx <= parseIdx;
	end

endmodule

`default_nettype wire

/* logic/spritePkg.sv */
`default_nettype none

package spritePkg;

	// Fast RAM geometry
	localparam int ADDR_W = 11;
	localparam int DATA_W = 16;
	localparam int SLOT_W = 5;	// 32 slots per group

	typedef logic [SLOT_W-1:0] slot_t;

	// Slot schedule, one group is 32 cycles of CLK_24M
	localparam slot_t SLOT_CPU_LAST = 5'd2;	// CPU owns 0..2
	localparam slot_t SLOT_PARSE_FIRST = 5'd3;	// Parse owns 3..18
	localparam slot_t SLOT_AL_READ = 5'd19;	// Render owns 19..31
	localparam slot_t SLOT_SCB2 = 5'd23;
	localparam slot_t SLOT_SCB3 = 5'd26;
	localparam slot_t SLOT_SCB4 = 5'd29;
	localparam int PARSE_WIN = 3;	// Slots per parse window
	localparam int PARSE_COUNT = 5;	// Windows per group

	// Sprite scan limits
	localparam int SPRITE_COUNT = 384;
	localparam int ACTIVE_MAX = 96;

	// Address map
	localparam logic [ADDR_W-1:0] SCB2_BASE = 11'h000;	// Shrink
	localparam logic [ADDR_W-1:0] SCB3_BASE = 11'h200;	// Y, sticky, size
	localparam logic [ADDR_W-1:0] SCB4_BASE = 11'h400;	// X
	localparam logic [ADDR_W-1:0] AL_BASE = 11'h600;	// 3'b110, then bank and entry

	// Bit 15 set in an active list word ends the list
	localparam logic [DATA_W-1:0] END_MARK = 16'h8000;

	// One client access for the slot it owns
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wrData;
		logic write;
	} vramReq_t;

	// Gathered sprite record for the renderer
	typedef struct packed {
		logic [8:0] index;
		logic [11:0] shrink;
		logic [8:0] xPos;
		logic [4:0] tileIdx;
		logic [3:0] tileLine;
		logic sticky;
		logic [5:0] size;
	} sprAttr_t;

endpackage

`default_nettype wire

/* tb.f */
logic/spritePkg.sv
logic/fastVram.sv
logic/slotSequencer.sv
logic/cpuPort.sv
logic/spriteParser.sv
logic/renderFetch.sv
logic/fastCycleTop.sv
tests/tbFastCycle.sv

/* tests/tbFastCycle.sv */
`default_nettype none

// Directed testbench for the fast VRAM slot path
module tbFastCycle import spritePkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 40;
	localparam int GROUP = 32;	// Cycles per slot group
	localparam int LINE_GROUPS = 100;	// Parser worst case is 97 groups
	// Up to two groups per host access, plus eight lines
	localparam int WATCH_GROUPS = 2 * (16 + 5 * SPRITE_COUNT) + 2 * 16 + 8 * LINE_GROUPS + 64;

	logic CLK_24M;
	logic TEST;
	logic lineBlank;
	logic [8:0] vCount;
	logic bankFlip;
	logic [ADDR_W-1:0] cpuAddr;
	logic reload;
	logic [10:0] vramMod;
	logic cpuWrite;
	logic [DATA_W-1:0] cpuWrData;
	logic [DATA_W-1:0] cpuRdData;
	logic writeAck;
	sprAttr_t sprAttr;
	logic sprValid;

	logic [DATA_W-1:0] shadow [1 << ADDR_W];	// RAM as written by the host
	logic [ADDR_W-1:0] hostAddr;	// Modeled host address register
	sprAttr_t got [$];	// Records seen in the last line
	sprAttr_t want [$];	// Model list
	integer seed;
	int errors;
	int testsOk;
	int testsBad;

	fastCycleTop dut (.*);

	initial
	begin
		CLK_24M = 1'b0;
		forever #(PERIOD / 2) CLK_24M = ~CLK_24M;
	end

	// Watchdog
	initial
	begin
		#(WATCH_GROUPS * GROUP * PERIOD);
		$display("Timeout: tests did not finish within %0d slot groups", WATCH_GROUPS);
		$display("Simulation failed");
		$finish;
	end

	// Inputs change and outputs are read 2 ns after the edge
	task automatic step();
		@(posedge CLK_24M);
		#2;
	endtask

	task automatic compareWord(input string name, input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic compareAttr(input string name, input sprAttr_t actual,
		input sprAttr_t expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic compareBit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errors == startErrors)
		begin
			testsOk++;
			$display("%s: ok", name);
		end
		else
		begin
			testsBad++;
			$display("%s: %0d errors", name, errors - startErrors);
		end
	endtask

	task automatic hostReload(input logic [ADDR_W-1:0] addr);
		cpuAddr = addr;
		reload = 1'b1;
		step();
		reload = 1'b0;
		hostAddr = addr;
	endtask

	// One write strobe, then wait for the acknowledge
	task automatic hostWrite(input logic [DATA_W-1:0] data);
		int waited;
		cpuWrData = data;
		cpuWrite = 1'b1;
		step();
		cpuWrite = 1'b0;
		waited = 0;
		while (!writeAck && waited < 3 * GROUP)
		begin
			step();
			waited++;
		end
		if (!writeAck)
		begin
			$display("No write acknowledge for host address %h", hostAddr);
			errors++;
		end
		else
		begin
			shadow[hostAddr] = data;
			hostAddr = hostAddr + vramMod;	// Wraps at 2048
			step();
			compareBit("writeAck", writeAck, 1'b0);	// Single cycle pulse
		end
	endtask

	task automatic hostRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		hostReload(addr);
		repeat (2 * GROUP) step();	// Next slot 0 read lands within a group
		data = cpuRdData;
	endtask

	// Table of SPRITE_COUNT random words, masked
	task automatic fillTable(input logic [ADDR_W-1:0] base, input logic [DATA_W-1:0] keep,
		input logic [DATA_W-1:0] set);
		logic [DATA_W-1:0] word;
		vramMod = 11'd1;
		hostReload(base);
		for (int i = 0; i < SPRITE_COUNT; i++)
		begin
			word = (DATA_W'($random(seed)) & keep) | set;
			hostWrite(word);
		end
	endtask

	// One lineBlank pulse, then a full line of collection
	task automatic runLine(input logic [8:0] vc, input logic bf);
		vCount = vc;
		bankFlip = bf;
		lineBlank = 1'b1;
		step();
		lineBlank = 1'b0;
		got.delete();
		repeat (LINE_GROUPS * GROUP)
		begin
			step();
			if (sprValid)
				got.push_back(sprAttr);
		end
	endtask

	// Height match over the shadow tables, then attribute gather
	task automatic modelLine(input logic [8:0] vc);
		logic [DATA_W-1:0] y;
		logic [8:0] offset;
		logic [8:0] line;
		sprAttr_t rec;
		want.delete();
		for (int i = 0; i < SPRITE_COUNT && want.size() < ACTIVE_MAX; i++)
		begin
			y = shadow[SCB3_BASE + ADDR_W'(i)];
			offset = y[15:7] + vc + 9'd1;
			if (y[5:0] != 6'd0 && {1'b0, offset[8:4]} < y[5:0])
			begin
				line = y[15:7] + vc;	// Same vCount on the render line
				rec.index = 9'(i);
				rec.shrink = shadow[SCB2_BASE + ADDR_W'(i)][11:0];
				rec.xPos = shadow[SCB4_BASE + ADDR_W'(i)][15:7];
				rec.tileIdx = line[8:4];
				rec.tileLine = line[3:0];
				rec.sticky = y[6];
				rec.size = y[5:0];
				want.push_back(rec);
			end
		end
	endtask

	task automatic checkRecords();
		compareWord("record count", 16'(got.size()), 16'(want.size()));
		for (int i = 0; i < got.size() && i < want.size(); i++)
			compareAttr($sformatf("sprAttr[%0d]", i), got[i], want[i]);
	endtask

	task automatic testReset();
		int start;
		start = errors;
		TEST = 1'b1;
		repeat (8)
		begin
			step();
			compareBit("writeAck", writeAck, 1'b0);
			compareBit("sprValid", sprValid, 1'b0);
		end
		TEST = 1'b0;
		repeat (2 * GROUP)
		begin
			step();
			compareBit("writeAck", writeAck, 1'b0);
			compareBit("sprValid", sprValid, 1'b0);
		end
		lineBlank = 1'b1;	// First line, no list behind it yet
		step();
		lineBlank = 1'b0;
		repeat (GROUP + 1)
		begin
			step();
			compareBit("writeAck", writeAck, 1'b0);
			compareBit("sprValid", sprValid, 1'b0);
		end
		finishTest("reset state", start);
	endtask

	task automatic testHostWrites();
		logic [ADDR_W-1:0] addrs [$];
		logic [DATA_W-1:0] data;
		int start;
		start = errors;
		vramMod = 11'd1;
		hostReload(11'h7E0);	// Clear of the active list region
		for (int i = 0; i < 16; i++)
		begin
			if (i == 8)
				vramMod = 11'h020;	// Crosses 2047 after one step
			addrs.push_back(hostAddr);
			hostWrite(DATA_W'($random(seed)));
		end
		vramMod = 11'd0;
		foreach (addrs[i])
		begin
			hostRead(addrs[i], data);
			compareWord($sformatf("cpuRdData @%h", addrs[i]), data, shadow[addrs[i]]);
		end
		finishTest("host writes", start);
	endtask

	task automatic testActiveList();
		int start;
		start = errors;
		fillTable(SCB2_BASE, 16'hFFFF, 16'h0000);
		fillTable(SCB3_BASE, 16'hFFC3, 16'h0000);	// Sizes 0..3, a short list
		fillTable(SCB4_BASE, 16'hFFFF, 16'h0000);
		runLine(9'd37, 1'b0);	// Build
		runLine(9'd37, 1'b1);	// Render
		modelLine(9'd37);
		checkRecords();
		finishTest("active list", start);
	endtask

	task automatic testEmptyLine();
		int start;
		start = errors;
		fillTable(SCB3_BASE, 16'hFFC0, 16'h0000);	// Every size 0
		runLine(9'd200, 1'b1);
		runLine(9'd200, 1'b0);
		compareWord("record count", 16'(got.size()), 16'd0);
		finishTest("empty line", start);
	endtask

	task automatic testCapacity();
		int start;
		start = errors;
		fillTable(SCB3_BASE, 16'hFFC0, 16'h003F);	// Size 63 always matches
		runLine(9'd5, 1'b0);
		runLine(9'd5, 1'b1);
		modelLine(9'd5);
		compareWord("record count", 16'(got.size()), 16'(ACTIVE_MAX));
		checkRecords();
		finishTest("list capacity", start);
	endtask

	initial
	begin
		TEST = 1'b1;
		lineBlank = 1'b0;
		vCount = '0;
		bankFlip = 1'b0;
		cpuAddr = '0;
		reload = 1'b0;
		vramMod = 11'd1;
		cpuWrite = 1'b0;
		cpuWrData = '0;
		hostAddr = '0;
		seed = 32'h3da2_79f6;
		errors = 0;
		testsOk = 0;
		testsBad = 0;
		testReset();
		testHostWrites();
		testActiveList();
		testEmptyLine();
		testCapacity();
		$display("Tests ok: %0d, with errors: %0d, total errors: %0d", testsOk, testsBad, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
